/* Makefile */
# Verilator simulation of the load-store OBI path

VERILATOR ?= verilator
TOP       ?= lsu_obi_tb
FILELIST  ?= lsu_obi.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/lsu_obi_top.sv */
// Load-store path to OBI memory
`default_nettype none

module lsu_obi_top (
  input  wire logic           clk,
  input  wire logic           rst_n,
  input  wire logic           gnt_throttle_i,
  input  wire logic           req_valid_i,
  input  wire logic           req_we_i,
  input  wire lsu_pkg::size_e req_size_i,
  input  wire logic           req_signed_i,
  input  wire obi_pkg::addr_t req_addr_i,
  input  wire obi_pkg::data_t req_wdata_i,
  output logic                req_ready_o,
  output logic                rsp_valid_o,
  output obi_pkg::data_t      rsp_rdata_o,
  output logic                rsp_err_o
);
  import obi_pkg::*;
  import lsu_pkg::*;

  // Request generator to adapter
  logic    trans_valid;
  logic    trans_ready;
  addr_t   trans_addr;
  logic    trans_we;
  be_t     trans_be;
  data_t   trans_wdata;

  // Request generator to aligner
  logic    pend_push;
  logic    pend_full;
  offset_t pend_offset;
  size_e   pend_size;
  logic    pend_signed;
  logic    pend_we;

  // OBI between adapter and memory
  logic    obi_req;
  logic    obi_gnt;
  addr_t   obi_addr;
  logic    obi_we;
  be_t     obi_be;
  data_t   obi_wdata;
  data_t   obi_rdata;
  logic    obi_rvalid;
  logic    obi_err;

  // Adapter to aligner
  logic    resp_valid;
  data_t   resp_rdata;
  logic    resp_err;

  lsu_request_gen request_gen_i (
    .req_valid_i  (req_valid_i),
    .req_we_i     (req_we_i),
    .req_size_i   (req_size_i),
    .req_signed_i (req_signed_i),
    .req_addr_i   (req_addr_i),
    .req_wdata_i  (req_wdata_i),
    .trans_ready_i(trans_ready),
    .pend_full_i  (pend_full),
    .req_ready_o  (req_ready_o),
    .trans_valid_o(trans_valid),
    .trans_addr_o (trans_addr),
    .trans_we_o   (trans_we),
    .trans_be_o   (trans_be),
    .trans_wdata_o(trans_wdata),
    .pend_push_o  (pend_push),
    .pend_offset_o(pend_offset),
    .pend_size_o  (pend_size),
    .pend_signed_o(pend_signed),
    .pend_we_o    (pend_we)
  );

  // The core may change its request before acceptance
  obi_adapter #(
    .trans_stable(1'b0)
  ) adapter_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .trans_valid_i(trans_valid),
    .trans_addr_i (trans_addr),
    .trans_we_i   (trans_we),
    .trans_be_i   (trans_be),
    .trans_wdata_i(trans_wdata),
    .obi_gnt_i    (obi_gnt),
    .obi_rdata_i  (obi_rdata),
    .obi_rvalid_i (obi_rvalid),
    .obi_err_i    (obi_err),
    .trans_ready_o(trans_ready),
    .resp_valid_o (resp_valid),
    .resp_rdata_o (resp_rdata),
    .resp_err_o   (resp_err),
    .obi_req_o    (obi_req),
    .obi_addr_o   (obi_addr),
    .obi_we_o     (obi_we),
    .obi_be_o     (obi_be),
    .obi_wdata_o  (obi_wdata)
  );

  obi_sram sram_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .gnt_throttle_i(gnt_throttle_i),
    .obi_req_i     (obi_req),
    .obi_addr_i    (obi_addr),
    .obi_we_i      (obi_we),
    .obi_be_i      (obi_be),
    .obi_wdata_i   (obi_wdata),
    .obi_gnt_o     (obi_gnt),
    .obi_rdata_o   (obi_rdata),
    .obi_rvalid_o  (obi_rvalid),
    .obi_err_o     (obi_err)
  );

  lsu_resp_align resp_align_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .pend_push_i  (pend_push),
    .pend_offset_i(pend_offset),
    .pend_size_i  (pend_size),
    .pend_signed_i(pend_signed),
    .pend_we_i    (pend_we),
    .resp_valid_i (resp_valid),
    .resp_rdata_i (resp_rdata),
    .resp_err_i   (resp_err),
    .pend_full_o  (pend_full),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_rdata_o  (rsp_rdata_o),
    .rsp_err_o    (rsp_err_o)
  );

endmodule

`default_nettype wire

/* hdl/lsu_pkg.sv */
// Load-store unit types
`default_nettype none

package lsu_pkg;

  ////////////////////////////////////////////////////////////////////
  // Access description
  ////////////////////////////////////////////////////////////////////

  // Size of a core access; the fourth encoding is not used
  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } size_e;

  // Byte position of an access within its word
  typedef logic [1:0] offset_t;

  ////////////////////////////////////////////////////////////////////
  // Pending-access queue
  ////////////////////////////////////////////////////////////////////

  // Number of accesses that can wait for their response
  localparam int unsigned pend_depth = 4;

  // Queue pointer, the top bit is the wrap flag
  typedef logic [2:0] pend_ptr_t;

endpackage

`default_nettype wire

/* hdl/lsu_request_gen.sv */
// Load-store request generator
`default_nettype none

module lsu_request_gen (
  input  wire logic           req_valid_i,
  input  wire logic           req_we_i,
  input  wire lsu_pkg::size_e req_size_i,
  input  wire logic           req_signed_i,
  input  wire obi_pkg::addr_t req_addr_i,
  input  wire obi_pkg::data_t req_wdata_i,
  input  wire logic           trans_ready_i,
  input  wire logic           pend_full_i,
  output logic                req_ready_o,
  output logic                trans_valid_o,
  output obi_pkg::addr_t      trans_addr_o,
  output logic                trans_we_o,
  output obi_pkg::be_t        trans_be_o,
  output obi_pkg::data_t      trans_wdata_o,
  output logic                pend_push_o,
  output lsu_pkg::offset_t    pend_offset_o,
  output lsu_pkg::size_e      pend_size_o,
  output logic                pend_signed_o,
  output logic                pend_we_o
);
  import obi_pkg::*;
  import lsu_pkg::*;

  offset_t offset;
  logic    aligned;

  // The byte offset is dropped from the bus address and kept for the aligner
  assign offset       = req_addr_i[1:0];
  assign trans_addr_o = {req_addr_i[31:2], 2'b00};
  assign trans_we_o   = req_we_i;

  // A full pending queue stalls the core and keeps the request off the bus
  assign trans_valid_o = req_valid_i && !pend_full_i;
  assign req_ready_o   = trans_ready_i && !pend_full_i;

  ////////////////////////////////////////////////////////////////////
  // Lane steering
  ////////////////////////////////////////////////////////////////////

  // Write data is replicated so that every possible lane carries it
  always_comb
  begin
    case (req_size_i)
      size_byte:
      begin
        trans_be_o    = be_t'(4'b0001 << offset);
        trans_wdata_o = {4{req_wdata_i[7:0]}};
        aligned       = 1'b1;
      end
      size_half:
      begin
        trans_be_o    = be_t'(4'b0011 << offset);
        trans_wdata_o = {2{req_wdata_i[15:0]}};
        aligned       = !offset[0];
      end
      default:
      begin
        trans_be_o    = 4'b1111;
        trans_wdata_o = req_wdata_i;
        aligned       = (offset == 2'b00);
      end
    endcase
  end

  // Every accepted access gets one queue entry for its response
  assign pend_push_o   = req_valid_i && req_ready_o;
  assign pend_offset_o = offset;
  assign pend_size_o   = req_size_i;
  assign pend_signed_o = req_signed_i;
  assign pend_we_o     = req_we_i;

  // Misaligned accesses are not split, so they must never be accepted
  always_comb
  begin
    if (pend_push_o)
    begin
      a_aligned: assert (aligned)
        else $error("Misaligned access to %h accepted", req_addr_i);
    end
  end

endmodule

`default_nettype wire

/* hdl/lsu_resp_align.sv */
// Load-store response aligner
`default_nettype none

module lsu_resp_align (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             pend_push_i,
  input  wire lsu_pkg::offset_t pend_offset_i,
  input  wire lsu_pkg::size_e   pend_size_i,
  input  wire logic             pend_signed_i,
  input  wire logic             pend_we_i,
  input  wire logic             resp_valid_i,
  input  wire obi_pkg::data_t   resp_rdata_i,
  input  wire logic             resp_err_i,
  output logic                  pend_full_o,
  output logic                  rsp_valid_o,
  output obi_pkg::data_t        rsp_rdata_o,
  output logic                  rsp_err_o
);
  import obi_pkg::*;
  import lsu_pkg::*;

  offset_t   offset_q [pend_depth];
  size_e     size_q   [pend_depth];
  logic      signed_q [pend_depth];
  logic      we_q     [pend_depth];
  pend_ptr_t wr_ptr_q;
  pend_ptr_t rd_ptr_q;
  logic      empty;
  data_t     shifted;
  pend_ptr_t head;

  ////////////////////////////////////////////////////////////////////
  // Pending-access FIFO
  ////////////////////////////////////////////////////////////////////

  // Equal pointers mean empty, differing only in wrap bit means full
  assign empty       = (wr_ptr_q == rd_ptr_q);
  assign pend_full_o = (wr_ptr_q[2] != rd_ptr_q[2]) && (wr_ptr_q[1:0] == rd_ptr_q[1:0]);

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end
    else
    begin
      if (pend_push_i)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (resp_valid_i)
        rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (pend_push_i)
    begin
      offset_q[wr_ptr_q[1:0]] <= pend_offset_i;
      size_q[wr_ptr_q[1:0]]   <= pend_size_i;
      signed_q[wr_ptr_q[1:0]] <= pend_signed_i;
      we_q[wr_ptr_q[1:0]]     <= pend_we_i;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Load extraction
  ////////////////////////////////////////////////////////////////////

  // Head entry describes the response on the bus this cycle
  assign head    = rd_ptr_q;
  assign shifted = resp_rdata_i >> {offset_q[head[1:0]], 3'b000};

  always_comb
  begin
    if (we_q[head[1:0]])
      rsp_rdata_o = '0;
    else
    begin
      case (size_q[head[1:0]])
        size_byte: rsp_rdata_o = {{24{signed_q[head[1:0]] & shifted[7]}}, shifted[7:0]};
        size_half: rsp_rdata_o = {{16{signed_q[head[1:0]] & shifted[15]}}, shifted[15:0]};
        default:   rsp_rdata_o = shifted;
      endcase
    end
  end

  assign rsp_valid_o = resp_valid_i;
  assign rsp_err_o   = resp_err_i;

  // Every response must match an access accepted earlier
  a_no_orphan: assert property (@(posedge clk) disable iff (!rst_n) resp_valid_i |-> !empty);

  // The request side must stall before the queue overflows
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    pend_push_i |-> !pend_full_o);

endmodule

`default_nettype wire

/* hdl/obi_adapter.sv */
// OBI A channel adapter
`default_nettype none

module obi_adapter #(
  // Set when the trans_* payload is held stable until accepted
  parameter bit trans_stable = 1'b0
) (
  input  wire logic           clk,
  input  wire logic           rst_n,
  input  wire logic           trans_valid_i,
  input  wire obi_pkg::addr_t trans_addr_i,
  input  wire logic           trans_we_i,
  input  wire obi_pkg::be_t   trans_be_i,
  input  wire obi_pkg::data_t trans_wdata_i,
  input  wire logic           obi_gnt_i,
  input  wire obi_pkg::data_t obi_rdata_i,
  input  wire logic           obi_rvalid_i,
  input  wire logic           obi_err_i,
  output logic                trans_ready_o,
  output logic                resp_valid_o,
  output obi_pkg::data_t      resp_rdata_o,
  output logic                resp_err_o,
  output logic                obi_req_o,
  output obi_pkg::addr_t      obi_addr_o,
  output logic                obi_we_o,
  output obi_pkg::be_t        obi_be_o,
  output obi_pkg::data_t      obi_wdata_o
);
  import obi_pkg::*;

  ////////////////////////////////////////////////////////////////////
  // R channel
  ////////////////////////////////////////////////////////////////////

  // Responses go straight through because the consumer is always ready
  assign resp_valid_o = obi_rvalid_i;
  assign resp_rdata_o = obi_rdata_i;
  assign resp_err_o   = obi_err_i;

  ////////////////////////////////////////////////////////////////////
  // A channel
  ////////////////////////////////////////////////////////////////////

  if (trans_stable)
  begin : g_direct
    // A stable source already meets OBI rules on its own
    assign obi_req_o     = trans_valid_i;
    assign obi_addr_o    = trans_addr_i;
    assign obi_we_o      = trans_we_i;
    assign obi_be_o      = trans_be_i;
    assign obi_wdata_o   = trans_wdata_i;
    assign trans_ready_o = obi_gnt_i;
  end
  else
  begin : g_hold
    typedef enum logic {st_transparent, st_registered} state_e;

    state_e state_q;
    state_e state_d;
    addr_t  addr_q;
    logic   we_q;
    be_t    be_q;
    data_t  wdata_q;

    // Leave transparent on an ungranted request, come back on the grant
    always_comb
    begin
      state_d = state_q;
      case (state_q)
        st_transparent:
        begin
          if (obi_req_o && !obi_gnt_i)
            state_d = st_registered;
        end
        default:
        begin
          if (obi_gnt_i)
            state_d = st_transparent;
        end
      endcase
    end

    // Registered state drives the captured address phase and never drops req
    always_comb
    begin
      if (state_q == st_transparent)
      begin
        obi_req_o   = trans_valid_i;
        obi_addr_o  = trans_addr_i;
        obi_we_o    = trans_we_i;
        obi_be_o    = trans_be_i;
        obi_wdata_o = trans_wdata_i;
      end
      else
      begin
        obi_req_o   = 1'b1;
        obi_addr_o  = addr_q;
        obi_we_o    = we_q;
        obi_be_o    = be_q;
        obi_wdata_o = wdata_q;
      end
    end

    always_ff @(posedge clk, negedge rst_n)
    begin
      if (!rst_n)
        state_q <= st_transparent;
      else
        state_q <= state_d;
    end

    // Capture happens only on the way into the registered state
    always_ff @(posedge clk)
    begin
      if (state_q == st_transparent && state_d == st_registered)
      begin
        addr_q  <= trans_addr_i;
        we_q    <= trans_we_i;
        be_q    <= trans_be_i;
        wdata_q <= trans_wdata_i;
      end
    end

    // Only the held request blocks new transfers since outstanding ones are not limited
    assign trans_ready_o = (state_q == st_transparent);

    // A waiting request is not withdrawn before its grant
    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
      obi_req_o && !obi_gnt_i |=> obi_req_o);

    // Address phase is frozen from the first ungranted cycle to the grant
    a_phase_stable: assert property (@(posedge clk) disable iff (!rst_n)
      obi_req_o && !obi_gnt_i |=> $stable(obi_addr_o) && $stable(obi_we_o)
        && $stable(obi_be_o) && $stable(obi_wdata_o));
  end

endmodule

`default_nettype wire

/* hdl/obi_pkg.sv */
// OBI bus types
`default_nettype none

package obi_pkg;

  ////////////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////////////

  // Byte address as seen on the OBI A channel
  typedef logic [31:0] addr_t;

  // One data word on either channel
  typedef logic [31:0] data_t;

  // One enable per byte lane of data_t
  typedef logic [3:0] be_t;

  ////////////////////////////////////////////////////////////////////
  // Memory geometry
  ////////////////////////////////////////////////////////////////////

  // Depth of the on-chip memory in words, 1 KiB in total
  localparam int unsigned mem_words = 256;

  // Word index into the memory array
  typedef logic [7:0] mem_index_t;

endpackage

`default_nettype wire

/* hdl/obi_sram.sv */
// OBI memory with grant throttle
`default_nettype none

module obi_sram (
  input  wire logic           clk,
  input  wire logic           rst_n,
  input  wire logic           gnt_throttle_i,
  input  wire logic           obi_req_i,
  input  wire obi_pkg::addr_t obi_addr_i,
  input  wire logic           obi_we_i,
  input  wire obi_pkg::be_t   obi_be_i,
  input  wire obi_pkg::data_t obi_wdata_i,
  output logic                obi_gnt_o,
  output obi_pkg::data_t      obi_rdata_o,
  output logic                obi_rvalid_o,
  output logic                obi_err_o
);
  import obi_pkg::*;

  data_t      mem_q [mem_words];
  logic [7:0] lfsr_q;
  logic       in_range;
  mem_index_t index;
  data_t      rdata_q;

  ////////////////////////////////////////////////////////////////////
  // Grant throttle
  ////////////////////////////////////////////////////////////////////

  // Maximal-length LFSR, taps 8 6 5 4, stepping on every cycle
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      lfsr_q <= 8'hA5;
    else
      lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
  end

  // About half of the cycles grant while throttling is on
  assign obi_gnt_o = obi_req_i && (!gnt_throttle_i || lfsr_q[0]);

  ////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////

  assign in_range = (obi_addr_i[31:2] < 30'(mem_words));
  assign index    = obi_addr_i[$bits(mem_index_t)+1:2];

  // Out-of-range writes are dropped without touching memory
  always_ff @(posedge clk)
  begin
    if (obi_gnt_o && obi_we_i && in_range)
    begin
      for (int b = 0; b < $bits(be_t); b++)
      begin
        if (obi_be_i[b])
          mem_q[index][b*8 +: 8] <= obi_wdata_i[b*8 +: 8];
      end
    end
  end

  // Read data for writes and faulting reads is zero
  always_ff @(posedge clk)
  begin
    if (obi_gnt_o)
      rdata_q <= (!obi_we_i && in_range) ? mem_q[index] : '0;
  end

  // One response per grant on the following cycle
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      obi_rvalid_o <= 1'b0;
      obi_err_o    <= 1'b0;
    end
    else
    begin
      obi_rvalid_o <= obi_gnt_o;
      obi_err_o    <= obi_gnt_o && !in_range;
    end
  end

  assign obi_rdata_o = rdata_q;

endmodule

`default_nettype wire

/* lsu_obi.f */
hdl/obi_pkg.sv
hdl/lsu_pkg.sv
hdl/lsu_request_gen.sv
hdl/obi_adapter.sv
hdl/obi_sram.sv
hdl/lsu_resp_align.sv
hdl/lsu_obi_top.sv
testbench/lsu_obi_tb.sv

/* testbench/lsu_obi_tb.sv */
// Load-store path testbench
`default_nettype none

module lsu_obi_tb;
  import obi_pkg::*;
  import lsu_pkg::*;

  // Cycles any single wait may last before it gives up
  localparam int wait_limit = 200;

  logic        clk;
  logic        rst_n;
  logic        gnt_throttle;
  logic        req_valid;
  logic        req_we;
  size_e       req_size;
  logic        req_signed;
  addr_t       req_addr;
  data_t       req_wdata;
  logic        req_ready;
  logic        rsp_valid;
  data_t       rsp_rdata;
  logic        rsp_err;

  // Byte-addressed copy of the memory contents
  logic [7:0]  ref_mem [mem_words*4];
  // Expected responses in acceptance order with err in the top bit
  logic [32:0] exp_q [$];
  logic        exp_avail;
  logic        exp_err;
  data_t       exp_data;
  logic        seen_accept;
  int          seed;
  int          value_errors;
  int          protocol_errors;
  int          timeouts;

  always #4 clk = ~clk;

  lsu_obi_top dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .gnt_throttle_i(gnt_throttle),
    .req_valid_i   (req_valid),
    .req_we_i      (req_we),
    .req_size_i    (req_size),
    .req_signed_i  (req_signed),
    .req_addr_i    (req_addr),
    .req_wdata_i   (req_wdata),
    .req_ready_o   (req_ready),
    .rsp_valid_o   (rsp_valid),
    .rsp_rdata_o   (rsp_rdata),
    .rsp_err_o     (rsp_err)
  );

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Applies one access to the byte model and returns its response
  task automatic model_access(input logic we, input size_e size, input logic sgn,
                              input addr_t addr, input data_t wdata,
                              output logic [32:0] result);
    logic [9:0] base;
    data_t      value;
    begin
      base = addr[9:0];
      if (addr[31:10] != '0)
        result = {1'b1, 32'h0};
      else if (we)
      begin
        // Stores take their data from the low lanes of the core word
        ref_mem[base] = wdata[7:0];
        if (size != size_byte)
          ref_mem[base + 10'd1] = wdata[15:8];
        if (size == size_word)
        begin
          ref_mem[base + 10'd2] = wdata[23:16];
          ref_mem[base + 10'd3] = wdata[31:24];
        end
        result = {1'b0, 32'h0};
      end
      else
      begin
        case (size)
          size_byte: value = {{24{sgn & ref_mem[base][7]}}, ref_mem[base]};
          size_half: value = {{16{sgn & ref_mem[base + 10'd1][7]}},
                              ref_mem[base + 10'd1], ref_mem[base]};
          default:   value = {ref_mem[base + 10'd3], ref_mem[base + 10'd2],
                              ref_mem[base + 10'd1], ref_mem[base]};
        endcase
        result = {1'b0, value};
      end
    end
  endtask

  // Known word contents that mix every address bit into the data
  function automatic data_t fill_word(input addr_t addr);
    return (addr * 32'h9E37_79B9) ^ 32'h5A5A_A5A5;
  endfunction

  // Pops on each response and pushes on each acceptance
  always @(posedge clk)
  begin
    logic [32:0] entry;
    if (!rst_n)
    begin
      exp_q.delete();
      exp_avail   <= 1'b0;
      seen_accept <= 1'b0;
    end
    else
    begin
      if (rsp_valid && exp_q.size() != 0)
        void'(exp_q.pop_front());
      if (req_valid && req_ready)
      begin
        model_access(req_we, req_size, req_signed, req_addr, req_wdata, entry);
        exp_q.push_back(entry);
        seen_accept <= 1'b1;
      end
      // Head as seen by the checks on the next edge
      exp_avail <= (exp_q.size() != 0);
      if (exp_q.size() != 0)
      begin
        exp_err  <= exp_q[0][32];
        exp_data <= exp_q[0][31:0];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  a_idle_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
    !seen_accept |-> req_ready && !rsp_valid)
    else
    begin
      protocol_errors++;
      $display("Before the first access req_ready_o was low or rsp_valid_o high at %0t", $time);
    end

  a_rsp_expected: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid |-> exp_avail)
    else
    begin
      protocol_errors++;
      $display("A response arrived at %0t while no access was pending", $time);
    end

  a_rsp_rdata: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && exp_avail |-> rsp_rdata == exp_data)
    else
    begin
      value_errors++;
      $display("** Error at %0t: rsp_rdata_o is %h, expected %h",
               $time, $sampled(rsp_rdata), $sampled(exp_data));
    end

  a_rsp_err: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && exp_avail |-> rsp_err == exp_err)
    else
    begin
      value_errors++;
      $display("** Error at %0t: rsp_err_o is %b, expected %b",
               $time, $sampled(rsp_err), $sampled(exp_err));
    end

  // Unthrottled memory answers on the very next cycle
  a_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    !gnt_throttle && req_valid && req_ready |=> rsp_valid)
    else
    begin
      value_errors++;
      $display("** Error at %0t: rsp_valid_o is 0, expected 1", $time);
    end

  // With every request granted the path takes one access per cycle
  a_full_rate: assert property (@(posedge clk) disable iff (!rst_n)
    !gnt_throttle && $past(!gnt_throttle) |-> req_ready)
    else
    begin
      protocol_errors++;
      $display("req_ready_o dropped at %0t although the throttle was off", $time);
    end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic report_and_finish();
    begin
      $display("Errors: %0d value, %0d protocol, %0d timeout",
               value_errors, protocol_errors, timeouts);
      if (value_errors + protocol_errors + timeouts == 0)
        $display("Done: no errors");
      else
        $display("Done: errors found");
      $finish;
    end
  endtask

  // Drives one access at the falling edge and holds it until accepted
  task automatic access(input logic we, input size_e size, input logic sgn,
                        input addr_t addr, input data_t wdata);
    int waited;
    begin
      @(negedge clk);
      req_valid  = 1'b1;
      req_we     = we;
      req_size   = size;
      req_signed = sgn;
      req_addr   = addr;
      req_wdata  = wdata;
      waited     = 0;
      @(posedge clk);
      while (!req_ready && waited < wait_limit)
      begin
        @(posedge clk);
        waited++;
      end
      if (!req_ready)
      begin
        timeouts++;
        $display("Access to %h was never accepted, timed out at %0t", addr, $time);
      end
    end
  endtask

  // Releases the request and waits until every response has come back
  task automatic drain();
    int waited;
    begin
      @(negedge clk);
      req_valid = 1'b0;
      waited    = 0;
      while (exp_q.size() != 0 && waited < wait_limit)
      begin
        @(negedge clk);
        waited++;
      end
      if (exp_q.size() != 0)
      begin
        timeouts++;
        $display("%0d responses still missing at %0t", exp_q.size(), $time);
      end
    end
  endtask

  task automatic set_throttle(input logic on);
    begin
      @(negedge clk);
      gnt_throttle = on;
    end
  endtask

  // Aligned random accesses inside the first 64 words
  task automatic random_burst(input int count);
    logic [31:0] r;
    data_t       wdata;
    size_e       size;
    addr_t       addr;
    begin
      for (int n = 0; n < count; n++)
      begin
        r     = $random(seed);
        wdata = $random(seed);
        case (r[1:0])
          2'd0:    size = size_byte;
          2'd1:    size = size_half;
          default: size = size_word;
        endcase
        addr = {24'h0, r[15:8]};
        if (size == size_half)
          addr[0] = 1'b0;
        if (size == size_word)
          addr[1:0] = 2'b00;
        access(r[2], size, r[3], addr, wdata);
      end
    end
  endtask

  initial
  begin
    clk             = 1'b0;
    rst_n           = 1'b0;
    gnt_throttle    = 1'b0;
    req_valid       = 1'b0;
    req_we          = 1'b0;
    req_size        = size_word;
    req_signed      = 1'b0;
    req_addr        = '0;
    req_wdata       = '0;
    seed            = 77679;
    value_errors    = 0;
    protocol_errors = 0;
    timeouts        = 0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    repeat (3) @(negedge clk);

    // Words 0 to 31 go unthrottled and words 32 to 63 with a throttled grant
    for (int i = 0; i < 32; i++)
      access(1'b1, size_word, 1'b0, addr_t'(i * 4), fill_word(addr_t'(i * 4)));
    for (int i = 0; i < 32; i++)
      access(1'b0, size_word, 1'b0, addr_t'(i * 4), 32'h0);
    drain();
    set_throttle(1'b1);
    for (int i = 32; i < 64; i++)
      access(1'b1, size_word, 1'b0, addr_t'(i * 4), fill_word(addr_t'(i * 4)));
    for (int i = 32; i < 64; i++)
      access(1'b0, size_word, 1'b0, addr_t'(i * 4), 32'h0);
    drain();
    set_throttle(1'b0);

    // Bytes 35 and 7F are positive while 8A and F0 are negative
    access(1'b1, size_word, 1'b0, 32'h100, 32'hF08A_7F35);
    for (int off = 0; off < 4; off++)
    begin
      for (int sgn = 0; sgn < 2; sgn++)
        access(1'b0, size_byte, sgn[0], 32'h100 + off, 32'h0);
    end
    for (int off = 0; off < 4; off += 2)
    begin
      for (int sgn = 0; sgn < 2; sgn++)
        access(1'b0, size_half, sgn[0], 32'h100 + off, 32'h0);
    end
    // Each byte store must leave the other three lanes alone
    for (int off = 0; off < 4; off++)
    begin
      access(1'b1, size_word, 1'b0, 32'h104, 32'h1122_3344);
      access(1'b1, size_byte, 1'b0, 32'h104 + off, 32'hC0 + off);
      access(1'b0, size_word, 1'b0, 32'h104, 32'h0);
    end
    drain();

    // Out-of-range accesses include addresses that alias word 0 in ten bits
    access(1'b0, size_word, 1'b0, 32'h400, 32'h0);
    access(1'b1, size_word, 1'b0, 32'h400, 32'hDEAD_BEEF);
    access(1'b1, size_byte, 1'b0, 32'h0001_0003, 32'h55);
    access(1'b0, size_half, 1'b1, 32'h0000_0FFE, 32'h0);
    access(1'b0, size_word, 1'b0, 32'h0, 32'h0);
    drain();

    set_throttle(1'b1);
    random_burst(48);
    drain();
    set_throttle(1'b0);
    random_burst(48);
    drain();
    report_and_finish();
  end

endmodule

`default_nettype wire
